// File: verilog/ahb_pkg.sv
/*
 * AHB protocol encodings
 * Transfer type, burst type and response as enums, plus the size type
 */

package ahb_pkg;

  // ----------------------------------------
  // Transfer type (HTRANS)
  // ----------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Master inserting wait in burst
    NONSEQ = 2'b10,  // First beat or single
    SEQ    = 2'b11   // Later beats of a burst
  } htrans_e;

  // ----------------------------------------
  // Burst type (HBURST)
  // ----------------------------------------
  typedef enum logic [2:0] {
    SINGLE = 3'b000,  // Single transfer
    INCR   = 3'b001,  // Undefined length incrementing
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

  // ----------------------------------------
  // Slave response (HRESP)
  // ----------------------------------------
  typedef enum logic [1:0] {
    OKAY  = 2'b00,
    ERROR = 2'b01,
    RETRY = 2'b10,  // Two-cycle, master retries
    SPLIT = 2'b11   // Two-cycle, arbiter parks master
  } hresp_e;

  // Transfer size, bytes = 2**hsize
  typedef logic [2:0] hsize_t;

endpackage

// File: verilog/instg_pkg.sv
/*
 * Input stage bundles
 * Control fields of one AHB transfer and the downstream slave response
 */

package instg_pkg;

  // ----------------------------------------
  // Transfer control bundle
  // ----------------------------------------
  // Address and master number stay outside, their widths are parameters
  typedef struct packed {
    logic             write;     // 1 = write
    ahb_pkg::hsize_t  size;      // Transfer size
    ahb_pkg::hburst_e burst;     // Burst type
    logic [3:0]       prot;      // Protection bits
    logic             mastlock;  // Locked sequence
  } ahb_ctrl_t;

  // ----------------------------------------
  // Downstream response
  // ----------------------------------------
  typedef struct packed {
    logic            readyout;  // Slave HREADYOUT
    ahb_pkg::hresp_e resp;      // Slave HRESP
  } slv_resp_t;

endpackage

// File: verilog/ahb_hold_reg.sv
/*
 * AHB input stage holding register
 * Parks an accepted transfer the output stage could not take, keeps the
 * pending flag, raises the held-transfer request and muxes direct or held path
 */

`timescale 1ns/10ps

module ahb_hold_reg #(
  parameter int ADDR_W   = 32,  // Address width
  parameter int MASTER_W = 4    // Master number width
) (
  input  logic                HCLK,
  input  logic                HRESETn,
  // Upstream address phase
  input  logic                hsel_s,
  input  logic [ADDR_W-1:0]   haddr_s,
  input  ahb_pkg::htrans_e    htrans_s,
  input  instg_pkg::ahb_ctrl_t hctrl_s,
  input  logic [MASTER_W-1:0] hmaster_s,
  input  logic                hready_s,
  // Output stage status
  input  logic                active_ip,  // Output stage serving this port
  input  logic                readyout,   // Downstream slave ready
  // Results
  output logic                load,       // Valid transfer accepted
  output logic                pend,       // Transfer parked
  output logic                held_tran_ip,
  output logic                sel_ip,
  output logic [ADDR_W-1:0]   addr_ip,
  output ahb_pkg::htrans_e    trans_int,  // Before burst rewrite
  output ahb_pkg::htrans_e    trans_b,    // Trans of presented transfer
  output instg_pkg::ahb_ctrl_t ctrl_int,  // Before burst rewrite
  output logic [MASTER_W-1:0] master_ip
);

  logic                 pend_next;
  ahb_pkg::htrans_e     reg_trans;   // Parked transfer type
  logic [ADDR_W-1:0]    reg_addr;
  instg_pkg::ahb_ctrl_t reg_ctrl;
  logic [MASTER_W-1:0]  reg_master;

  // ----------------------------------------
  // Accept and pending flag
  // ----------------------------------------

  // Selected, NONSEQ or SEQ, and upstream ready
  assign load = hsel_s & htrans_s[1] & hready_s;

  // Set when accepted but output stage busy
  // Clear once driven downstream and slave ready
  always_comb
  begin
    if (load && !active_ip)
      pend_next = 1'b1;
    else if (active_ip && readyout)
      pend_next = 1'b0;
    else
      pend_next = pend;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend <= 1'b0;
    else
      pend <= pend_next;
  end

  // Request to arbitration, direct or held
  assign held_tran_ip = load | pend;

  // ----------------------------------------
  // Holding register
  // ----------------------------------------
  // Captures every accepted transfer, only used while pend is set
  always_ff @(posedge HCLK)
  begin
    if (load)
    begin
      reg_trans  <= htrans_s;
      reg_addr   <= haddr_s;
      reg_ctrl   <= hctrl_s;
      reg_master <= hmaster_s;
    end
  end

  // ----------------------------------------
  // Direct / held path mux
  // ----------------------------------------
  always_comb
  begin
    if (!pend)
    begin
      sel_ip    = hsel_s;     // Straight through
      addr_ip   = haddr_s;
      trans_int = htrans_s;
      ctrl_int  = hctrl_s;
      master_ip = hmaster_s;
      trans_b   = htrans_s;
    end
    else
    begin
      sel_ip    = 1'b1;             // Replay always selected
      addr_ip   = reg_addr;
      trans_int = ahb_pkg::NONSEQ;  // Replay starts fresh
      ctrl_int  = reg_ctrl;
      master_ip = reg_master;
      trans_b   = reg_trans;        // Original type, for burst fixup
    end
  end

endmodule

// File: verilog/ahb_resp_mux.sv
/*
 * AHB input stage response mux
 * Tracks the data phase and picks the upstream ready and response
 */

`timescale 1ns/10ps

module ahb_resp_mux (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  input  logic                 hsel_s,
  input  logic                 hready_s,
  input  ahb_pkg::htrans_e     htrans_s,
  input  logic                 pend,         // Transfer parked in stage
  input  instg_pkg::slv_resp_t slv_resp,     // From downstream slave
  output logic                 hreadyout_s,
  output ahb_pkg::hresp_e      hresp_s
);

  logic addr_valid;  // Address phase of valid transfer here
  logic data_valid;  // Data phase of valid transfer here

  assign addr_valid = hsel_s & htrans_s[1];

  // Advances with the upstream bus pipeline
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (hready_s)
      data_valid <= addr_valid;
  end

  // ----------------------------------------
  // Ready and response select
  // ----------------------------------------
  always_comb
  begin
    if (!data_valid)
    begin
      hreadyout_s = 1'b1;  // Not ours, or IDLE/BUSY
      hresp_s     = ahb_pkg::OKAY;
    end
    else if (pend)
    begin
      hreadyout_s = 1'b0;  // Stall while held
      hresp_s     = ahb_pkg::OKAY;
    end
    else
    begin
      hreadyout_s = slv_resp.readyout;
      hresp_s     = slv_resp.resp;
    end
  end

endmodule

// File: verilog/ahb_burst_term.sv
/*
 * AHB input stage early burst termination
 * Keeps the burst override state and wrap boundary flag, and rewrites
 * HTRANS and HBURST so an interrupted burst stays legal downstream
 */

`timescale 1ns/10ps

module ahb_burst_term #(
  parameter int ADDR_W = 32  // Address width, 7 or more
) (
  input  logic              HCLK,
  input  logic              HRESETn,
  // Upstream address phase
  input  logic [ADDR_W-1:0] haddr_s,
  input  ahb_pkg::htrans_e  htrans_s,
  input  ahb_pkg::hsize_t   hsize_s,
  input  ahb_pkg::hburst_e  hburst_s,
  input  logic              hready_s,
  // From holding register
  input  logic              load,
  input  logic              active_ip,
  input  ahb_pkg::htrans_e  trans_b,    // Type of presented transfer
  input  ahb_pkg::htrans_e  trans_int,  // Muxed trans
  input  ahb_pkg::hburst_e  burst_int,  // Muxed burst
  // To output stage
  output ahb_pkg::htrans_e  trans_ip,
  output ahb_pkg::hburst_e  burst_ip
);

  logic       override;       // Burst was cut by output stage
  logic       override_next;
  logic [3:0] offset_addr;    // Beat number within 16 beats
  logic [3:0] check_addr;     // Offset masked by wrap length
  logic       bound;          // Last beat before wrap seen
  logic       bound_next;
  logic       bound_en;

  // ----------------------------------------
  // Burst override state
  // ----------------------------------------
  always_comb
  begin
    if (htrans_s == ahb_pkg::NONSEQ || htrans_s == ahb_pkg::IDLE)
      override_next = 1'b0;             // New burst or end of burst
    else if (htrans_s == ahb_pkg::SEQ && load && !active_ip)
      override_next = 1'b1;             // Burst interrupted mid-way
    else
      override_next = override;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      override <= 1'b0;
    else if (hready_s)
      override <= override_next;
  end

  // ----------------------------------------
  // Wrap boundary detection
  // ----------------------------------------
  always_comb
  begin
    case (hsize_s)
      3'd0:    offset_addr = haddr_s[3:0];  // Byte
      3'd1:    offset_addr = haddr_s[4:1];  // Halfword
      3'd2:    offset_addr = haddr_s[5:2];  // Word
      3'd3:    offset_addr = haddr_s[6:3];  // Doubleword
      default: offset_addr = haddr_s[3:0];  // 128 bits and up, byte slice
    endcase
  end

  // Bits above the wrap length forced high
  always_comb
  begin
    case (hburst_s)
      ahb_pkg::WRAP4:  check_addr = {2'b11, offset_addr[1:0]};
      ahb_pkg::WRAP8:  check_addr = {1'b1, offset_addr[2:0]};
      ahb_pkg::WRAP16: check_addr = offset_addr;
      default:         check_addr = 4'b0000;  // Incrementing never wraps
    endcase
  end

  assign bound_next = &check_addr;
  assign bound_en   = htrans_s[1] & hready_s;  // Active beats only

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound <= 1'b0;
    else if (bound_en)
      bound <= bound_next;
  end

  // ----------------------------------------
  // HTRANS / HBURST rewrite
  // ----------------------------------------
  // At the wrap point SEQ -> NONSEQ, BUSY -> IDLE
  assign trans_ip = (override && bound) ? ahb_pkg::htrans_e'({trans_int[1], 1'b0})
                                        : trans_int;

  // Remaining beats carry on as undefined-length burst
  assign burst_ip = (override && trans_b != ahb_pkg::NONSEQ) ? ahb_pkg::INCR
                                                             : burst_int;

endmodule

// File: verilog/l1_ahb_input_stage.sv
/*
 * AHB input stage for a multi-layer interconnect
 * Holds a transfer the output stage cannot take, stalls the master,
 * and keeps interrupted bursts legal on the way downstream
 */

`timescale 1ns/10ps

module l1_ahb_input_stage #(
  parameter int ADDR_W   = 32,  // Address width, 7 or more
  parameter int MASTER_W = 4    // Master number width
) (
  input  logic                 HCLK,
  input  logic                 HRESETn,

  // ----------------------------------------
  // Upstream AHB port
  // ----------------------------------------
  input  logic                 hsel_s,
  input  logic [ADDR_W-1:0]    haddr_s,
  input  ahb_pkg::htrans_e     htrans_s,
  input  instg_pkg::ahb_ctrl_t hctrl_s,
  input  logic [MASTER_W-1:0]  hmaster_s,
  input  logic                 hready_s,
  output logic                 hreadyout_s,
  output ahb_pkg::hresp_e      hresp_s,

  // ----------------------------------------
  // Output stage side
  // ----------------------------------------
  input  logic                 active_ip,     // Output stage serving us
  input  instg_pkg::slv_resp_t slv_resp,
  output logic                 sel_ip,
  output logic [ADDR_W-1:0]    addr_ip,
  output ahb_pkg::htrans_e     trans_ip,
  output instg_pkg::ahb_ctrl_t ctrl_ip,
  output logic [MASTER_W-1:0]  master_ip,
  output logic                 held_tran_ip   // Arbitration request
);

  logic                 load;       // Transfer accepted
  logic                 pend;       // Transfer parked
  ahb_pkg::htrans_e     trans_b;
  ahb_pkg::htrans_e     trans_int;
  instg_pkg::ahb_ctrl_t ctrl_int;
  ahb_pkg::hburst_e     burst_ip;   // Rewritten burst

  ahb_hold_reg #(
    .ADDR_W   (ADDR_W),
    .MASTER_W (MASTER_W)
  ) i_ahb_hold_reg (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .hsel_s       (hsel_s),
    .haddr_s      (haddr_s),
    .htrans_s     (htrans_s),
    .hctrl_s      (hctrl_s),
    .hmaster_s    (hmaster_s),
    .hready_s     (hready_s),
    .active_ip    (active_ip),
    .readyout     (slv_resp.readyout),
    .load         (load),
    .pend         (pend),
    .held_tran_ip (held_tran_ip),
    .sel_ip       (sel_ip),
    .addr_ip      (addr_ip),
    .trans_int    (trans_int),
    .trans_b      (trans_b),
    .ctrl_int     (ctrl_int),
    .master_ip    (master_ip)
  );

  ahb_resp_mux i_ahb_resp_mux (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .hsel_s      (hsel_s),
    .hready_s    (hready_s),
    .htrans_s    (htrans_s),
    .pend        (pend),
    .slv_resp    (slv_resp),
    .hreadyout_s (hreadyout_s),
    .hresp_s     (hresp_s)
  );

  // Boundary logic looks at the live upstream size and burst
  ahb_burst_term #(
    .ADDR_W (ADDR_W)
  ) i_ahb_burst_term (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .haddr_s   (haddr_s),
    .htrans_s  (htrans_s),
    .hsize_s   (hctrl_s.size),
    .hburst_s  (hctrl_s.burst),
    .hready_s  (hready_s),
    .load      (load),
    .active_ip (active_ip),
    .trans_b   (trans_b),
    .trans_int (trans_int),
    .burst_int (ctrl_int.burst),
    .trans_ip  (trans_ip),
    .burst_ip  (burst_ip)
  );

  // Control bundle out, burst field replaced
  always_comb
  begin
    ctrl_ip       = ctrl_int;
    ctrl_ip.burst = burst_ip;
  end

endmodule

// File: tb/tb_l1_ahb_input_stage.sv
/*
 * Testbench for the AHB input stage
 * Random stimulus checked every cycle against a cycle model of the
 * holding register, response select and burst rewrite
 */

`timescale 1ns/10ps

module tb_l1_ahb_input_stage;

  localparam int ADDR_W   = 32;
  localparam int MASTER_W = 4;
  localparam int N_CYC    = 400;   // Cycles per directed test
  localparam int N_RAND   = 2000;  // Cycles of the fully random run
  localparam int TOTAL    = 5 * N_CYC + N_RAND + 4;

  logic                 HCLK;
  logic                 HRESETn;
  logic                 hsel_s;
  logic [ADDR_W-1:0]    haddr_s;
  ahb_pkg::htrans_e     htrans_s;
  instg_pkg::ahb_ctrl_t hctrl_s;
  logic [MASTER_W-1:0]  hmaster_s;
  logic                 hready_s;
  logic                 hreadyout_s;
  ahb_pkg::hresp_e      hresp_s;
  logic                 active_ip;
  instg_pkg::slv_resp_t slv_resp;
  logic                 sel_ip;
  logic [ADDR_W-1:0]    addr_ip;
  ahb_pkg::htrans_e     trans_ip;
  instg_pkg::ahb_ctrl_t ctrl_ip;
  logic [MASTER_W-1:0]  master_ip;
  logic                 held_tran_ip;

  // Model state
  logic                 m_pend;
  logic                 m_dv;      // Data phase valid
  logic                 m_ovr;     // Burst override
  logic                 m_bound;   // Last beat before wrap
  logic [ADDR_W-1:0]    h_addr;
  ahb_pkg::htrans_e     h_trans;
  instg_pkg::ahb_ctrl_t h_ctrl;
  logic [MASTER_W-1:0]  h_master;

  int seed;
  int errors;
  int checks;
  int h_phase;  // Holding test phase (0 accepts next)
  int h_wait;   // Busy cycles left
  int g_left;   // Beats left in burst

  l1_ahb_input_stage #(
    .ADDR_W   (ADDR_W),
    .MASTER_W (MASTER_W)
  ) i_l1_ahb_input_stage (.*);

  always #5 HCLK = ~HCLK;

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // Upstream ready the model expects for the drawn slv_resp
  function automatic logic exp_ready();
    return !m_dv || (!m_pend && slv_resp.readyout);
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------
  // One cycle of checks and model update
  // ----------------------------------------
  task automatic step();
    logic                 load;
    logic [3:0]           beat;
    logic [3:0]           lenm;
    logic [1:0]           resp;
    ahb_pkg::htrans_e     t_int;
    ahb_pkg::htrans_e     t_b;
    instg_pkg::ahb_ctrl_t c_int;
    #1;                                   // Let comb paths settle
    load  = hsel_s && htrans_s[1] && hready_s;
    t_int = m_pend ? ahb_pkg::NONSEQ : htrans_s;
    t_b   = m_pend ? h_trans : htrans_s;
    c_int = m_pend ? h_ctrl : hctrl_s;
    if (m_ovr && t_b != ahb_pkg::NONSEQ)
      c_int.burst = ahb_pkg::INCR;        // Cut burst goes on as INCR
    if (m_ovr && m_bound && t_int == ahb_pkg::SEQ)
      t_int = ahb_pkg::NONSEQ;
    else if (m_ovr && m_bound && t_int == ahb_pkg::BUSY)
      t_int = ahb_pkg::IDLE;
    resp = (m_dv && !m_pend) ? slv_resp.resp : ahb_pkg::OKAY;
    check_value("sel_ip", sel_ip, m_pend | hsel_s);
    check_value("addr_ip", addr_ip, m_pend ? h_addr : haddr_s);
    check_value("trans_ip", trans_ip, t_int);
    check_value("ctrl_ip", ctrl_ip, c_int);
    check_value("master_ip", master_ip, m_pend ? h_master : hmaster_s);
    check_value("held_tran_ip", held_tran_ip, load | m_pend);
    check_value("hreadyout_s", hreadyout_s, exp_ready());
    check_value("hresp_s", hresp_s, resp);
    @(posedge HCLK);
    if (load && !active_ip)
      m_pend = 1'b1;
    else if (active_ip && slv_resp.readyout)
      m_pend = 1'b0;
    if (load)
    begin
      h_addr   = haddr_s;
      h_trans  = htrans_s;
      h_ctrl   = hctrl_s;
      h_master = hmaster_s;
    end
    if (hready_s)
    begin
      m_dv = hsel_s && htrans_s[1];
      if (htrans_s == ahb_pkg::NONSEQ || htrans_s == ahb_pkg::IDLE)
        m_ovr = 1'b0;
      else if (htrans_s == ahb_pkg::SEQ && load && !active_ip)
        m_ovr = 1'b1;
      if (htrans_s[1])
      begin
        beat = 4'(haddr_s >> ((hctrl_s.size > 3'd3) ? 3'd0 : hctrl_s.size));
        case (hctrl_s.burst)
          ahb_pkg::WRAP4:  lenm = 4'd3;
          ahb_pkg::WRAP8:  lenm = 4'd7;
          ahb_pkg::WRAP16: lenm = 4'd15;
          default:         lenm = 4'd0;   // Incrementing never wraps
        endcase
        m_bound = (lenm != 4'd0) && ((beat & lenm) == lenm);
      end
    end
    @(negedge HCLK);
  endtask

  // ----------------------------------------
  // Stimulus driven on the falling edge
  // ----------------------------------------
  task automatic drive_transfer();
    hsel_s    = (rnd() % 4) != 0;
    haddr_s   = ADDR_W'(rnd());
    htrans_s  = ahb_pkg::htrans_e'(2'(rnd()));
    hctrl_s   = instg_pkg::ahb_ctrl_t'(12'(rnd()));
    hmaster_s = MASTER_W'(rnd());
    slv_resp  = instg_pkg::slv_resp_t'(3'(rnd()));
    slv_resp.readyout = (rnd() % 4) != 0;  // Mostly ready
  endtask

  task automatic drive_hold();
    if (h_phase == 1 && h_wait == 0 && !m_pend)
      h_phase = 0;                        // Replay done
    drive_transfer();
    if (h_phase == 0)
    begin
      hsel_s            = 1'b1;
      htrans_s          = ahb_pkg::NONSEQ;
      active_ip         = 1'b0;           // Output stage busy
      slv_resp.readyout = 1'b1;
      h_wait            = 1 + rnd() % 4;
      h_phase           = 1;
    end
    else if (h_wait != 0)
    begin
      active_ip = 1'b0;
      h_wait--;
    end
    else
      active_ip = 1'b1;
    hready_s = exp_ready();
  endtask

  task automatic drive_burst(input logic wrap_only);
    logic [31:0] bytes;
    logic [31:0] blk;
    if (hready_s)                         // Beat taken so master moves on
    begin
      bytes = 32'd1 << hctrl_s.size;
      blk   = bytes * ((hctrl_s.burst == ahb_pkg::WRAP4) ? 4 :
                       (hctrl_s.burst == ahb_pkg::WRAP8) ? 8 : 16);
      if (g_left == 0)
      begin
        drive_transfer();
        hsel_s        = 1'b1;
        hctrl_s.size  = 3'(rnd() % 5);
        hctrl_s.burst = wrap_only ? ahb_pkg::hburst_e'(3'(2 * (1 + rnd() % 3)))
                                  : ahb_pkg::hburst_e'(3'(rnd()));
        haddr_s       = haddr_s & ~((32'd1 << hctrl_s.size) - 1);  // Aligned
        case (hctrl_s.burst)
          ahb_pkg::SINGLE: g_left = 0;
          ahb_pkg::INCR:   g_left = rnd() % 8;
          ahb_pkg::WRAP4, ahb_pkg::INCR4: g_left = 3;
          ahb_pkg::WRAP8, ahb_pkg::INCR8: g_left = 7;
          default:         g_left = 15;
        endcase
        htrans_s = ahb_pkg::NONSEQ;
        if ((rnd() % 4) == 0)
        begin
          htrans_s = ahb_pkg::IDLE;       // Gap between bursts
          g_left   = 0;
        end
      end
      else if ((rnd() % 4) == 0)
        htrans_s = ahb_pkg::BUSY;         // Same address without a beat
      else
      begin
        if (hctrl_s.burst inside {ahb_pkg::WRAP4, ahb_pkg::WRAP8, ahb_pkg::WRAP16})
          haddr_s = (haddr_s & ~(blk - 1)) | ((haddr_s + bytes) & (blk - 1));
        else
          haddr_s = haddr_s + bytes;
        htrans_s = ahb_pkg::SEQ;
        g_left--;
      end
    end
    slv_resp          = instg_pkg::slv_resp_t'(3'(rnd()));
    slv_resp.readyout = (rnd() % 4) != 0;
    active_ip         = m_pend ? (rnd() % 3) != 0 : (rnd() % 4) != 0;
    hready_s          = exp_ready();
  endtask

  task automatic run_test(input int num, input string name, input int n);
    int err0;
    err0 = errors;
    for (int i = 0; i < n; i++)
    begin
      case (num)
        1:
        begin
          drive_transfer();
          hready_s          = (rnd() % 8) != 0;
          active_ip         = 1'b1;
          slv_resp.readyout = 1'b1;
        end
        2: drive_hold();
        3:
        begin
          drive_transfer();
          active_ip = (rnd() % 4) != 0;
          hready_s  = exp_ready();
        end
        4: drive_burst(1'b0);
        5: drive_burst(1'b1);
        default:
        begin
          drive_transfer();
          active_ip = 1'(rnd());
          hready_s  = 1'(rnd());
        end
      endcase
      step();
    end
    $display("Test %0d %s: %0d cycles, %0d errors", num, name, n, errors - err0);
  endtask

  // ----------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------
  initial
  begin
    seed      = 32'hf1be_e24c;
    HCLK      = 1'b0;
    HRESETn   = 1'b0;
    hsel_s    = 1'b0;
    haddr_s   = '0;
    htrans_s  = ahb_pkg::IDLE;
    hctrl_s   = '0;
    hmaster_s = '0;
    hready_s  = 1'b1;
    active_ip = 1'b1;
    slv_resp  = '{readyout: 1'b1, resp: ahb_pkg::OKAY};
    m_pend    = 1'b0;
    m_dv      = 1'b0;
    m_ovr     = 1'b0;
    m_bound   = 1'b0;
    h_addr    = '0;
    h_trans   = ahb_pkg::IDLE;
    h_ctrl    = '0;
    h_master  = '0;
    repeat (2) @(posedge HCLK);           // Reset for two cycles
    @(negedge HCLK);
    HRESETn = 1'b1;
    run_test(1, "pass-through", N_CYC);
    run_test(2, "holding and replay", N_CYC);
    run_test(3, "response selection", N_CYC);
    run_test(4, "early burst termination", N_CYC);
    run_test(5, "wrap boundary", N_CYC);
    run_test(6, "fully random", N_RAND);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  initial
  begin
    #(TOTAL * 10 + 1000);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Something failed");
    $finish;
  end

endmodule

// File: files.f
verilog/ahb_pkg.sv
verilog/instg_pkg.sv
verilog/ahb_hold_reg.sv
verilog/ahb_resp_mux.sv
verilog/ahb_burst_term.sv
verilog/l1_ahb_input_stage.sv
tb/tb_l1_ahb_input_stage.sv

// File: Bender.yml
package:
  name: l1_ahb_input_stage

sources:
  # Packages first, then RTL bottom-up
  - verilog/ahb_pkg.sv
  - verilog/instg_pkg.sv
  - verilog/ahb_hold_reg.sv
  - verilog/ahb_resp_mux.sv
  - verilog/ahb_burst_term.sv
  - verilog/l1_ahb_input_stage.sv
  - target: test
    files:
      - tb/tb_l1_ahb_input_stage.sv
